// File: demux_pkg.sv
/*
 * read demux shared definitions
 * widths, port counts and the packed AR and R payloads used by the
 * spill registers, the dispatch stage and the R arbiter
 */

`default_nettype none

package demux_pkg;

  // ------------------------------------------------------------------------
  // port and field widths
  // ------------------------------------------------------------------------

  // master side fan-out
  localparam int unsigned NUM_MST = 4;
  localparam int unsigned SEL_W = 2;

  // axi id and the slice of it that indexes the in-flight counters
  localparam int unsigned ID_W = 4;
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned NUM_LOOK = 2 ** LOOK_BITS;

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned LEN_W = 4;
  localparam int unsigned DATA_W = 32;

  // a counter saturates at all ones, so 7 reads per id at most
  localparam int unsigned CNT_W = 3;

  // ------------------------------------------------------------------------
  // scalar types
  // ------------------------------------------------------------------------

  typedef logic [SEL_W-1:0] sel_t;
  typedef logic [ID_W-1:0] id_t;
  typedef logic [LOOK_BITS-1:0] look_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0] len_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // ------------------------------------------------------------------------
  // channel payloads
  // ------------------------------------------------------------------------

  // read request with the target master appended in the low bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    sel_t  sel;
  } ar_beat_t;

  // read data beat as merged onto the slave port
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_beat_t;

endpackage

`default_nettype wire

// File: spill_reg.sv
/*
 * spill register
 * two-slot valid/ready buffer that breaks every combinational path
 * between its input and output side, payload type set by parameter
 */

`default_nettype none

module spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  // upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // ------------------------------------------------------------------------
  // slot a takes new items, slot b holds the spilled one
  // ------------------------------------------------------------------------

  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // accept while at least one slot is free
  assign ready_o = ~a_full_q | ~b_full_q;
  assign a_fill  = valid_i & ready_o;

  // a moves on only when b is empty, either out or into b
  assign a_drain = a_full_q & ~b_full_q;

  // stalled output with a draining means a spills into b
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // ------------------------------------------------------------------------
  // output, b is always the older item
  // ------------------------------------------------------------------------

  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: ar_id_tracker.sv
/*
 * AR id tracker
 * per-id in-flight counters with the master each id was last sent to,
 * looked up by the dispatch stage to keep reads of one id in order
 */

`default_nettype none

module ar_id_tracker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // lookup of the pending request
  input  demux_pkg::look_t  lookup_id_i,
  output demux_pkg::sel_t   lookup_sel_o,
  output logic              lookup_busy_o,
  output logic              full_o,
  // request sent to a master
  input  logic              push_i,
  input  demux_pkg::look_t  push_id_i,
  input  demux_pkg::sel_t   push_sel_i,
  // last read beat returned
  input  logic              pop_i,
  input  demux_pkg::look_t  pop_id_i
);

  import demux_pkg::*;

  // ------------------------------------------------------------------------
  // state
  // ------------------------------------------------------------------------

  cnt_t [NUM_LOOK-1:0] cnt_q;
  sel_t [NUM_LOOK-1:0] sel_q;

  logic [NUM_LOOK-1:0] push_en;
  logic [NUM_LOOK-1:0] pop_en;
  logic [NUM_LOOK-1:0] busy;
  logic [NUM_LOOK-1:0] cnt_full;

  // one-hot decode of push and pop ids
  always_comb begin
    for (int unsigned i = 0; i < NUM_LOOK; i++) begin
      push_en[i]  = push_i & (push_id_i == look_t'(i));
      pop_en[i]   = pop_i & (pop_id_i == look_t'(i));
      busy[i]     = |cnt_q[i];
      // saturated counter blocks all new requests
      cnt_full[i] = &cnt_q[i];
    end
  end

  // ------------------------------------------------------------------------
  // counters and remembered master
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NUM_LOOK; i++) begin
        // push and pop on one id cancel out
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
        if (push_en[i]) begin
          sel_q[i] <= push_sel_i;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------------------

  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = busy[lookup_id_i];
  assign full_o        = |cnt_full;

endmodule

`default_nettype wire

// File: ar_dispatch.sv
/*
 * AR dispatch
 * checks id ordering against the tracker, locks an offered request until
 * the master takes it, routes AR to the selected master
 */

`default_nettype none

module ar_dispatch (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // request from the AR spill register
  input  logic                                  ar_valid_i,
  output logic                                  ar_ready_o,
  input  demux_pkg::ar_beat_t                   ar_beat_i,
  // master AR ports, payload shared by all
  output logic [demux_pkg::NUM_MST-1:0]         m_ar_valid_o,
  input  logic [demux_pkg::NUM_MST-1:0]         m_ar_ready_i,
  output demux_pkg::id_t                        m_ar_id_o,
  output demux_pkg::addr_t                      m_ar_addr_o,
  output demux_pkg::len_t                       m_ar_len_o,
  // completion from the R arbiter
  input  logic                                  r_done_i,
  input  demux_pkg::id_t                        r_done_id_i
);

  import demux_pkg::*;

  sel_t lookup_sel;
  logic lookup_busy;
  logic cnt_full;
  logic push;

  logic lock_q;
  logic lock_d;
  logic ar_valid;
  logic mst_ready;

  // ------------------------------------------------------------------------
  // handshake control
  // ------------------------------------------------------------------------

  // ready of the master this request is routed to
  assign mst_ready = m_ar_ready_i[ar_beat_i.sel];

  always_comb begin
    ar_valid   = 1'b0;
    ar_ready_o = 1'b0;
    push       = 1'b0;
    lock_d     = lock_q;
    if (lock_q) begin
      // already offered, valid must not drop before the transfer
      ar_valid = 1'b1;
      if (mst_ready) begin
        ar_ready_o = 1'b1;
        push       = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (!cnt_full && ar_valid_i &&
                 (!lookup_busy || (lookup_sel == ar_beat_i.sel))) begin
      // id idle or already bound to the same master
      ar_valid = 1'b1;
      if (mst_ready) begin
        ar_ready_o = 1'b1;
        push       = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ------------------------------------------------------------------------
  // in-flight tracking, indexed by the low id bits
  // ------------------------------------------------------------------------

  ar_id_tracker u_ar_id_tracker (
    .clk_i         ( clk_i                          ),
    .rst_n_i       ( rst_n_i                        ),
    .lookup_id_i   ( ar_beat_i.id[LOOK_BITS-1:0]    ),
    .lookup_sel_o  ( lookup_sel                     ),
    .lookup_busy_o ( lookup_busy                    ),
    .full_o        ( cnt_full                       ),
    .push_i        ( push                           ),
    .push_id_i     ( ar_beat_i.id[LOOK_BITS-1:0]    ),
    .push_sel_i    ( ar_beat_i.sel                  ),
    .pop_i         ( r_done_i                       ),
    .pop_id_i      ( r_done_id_i[LOOK_BITS-1:0]     )
  );

  // ------------------------------------------------------------------------
  // routing
  // ------------------------------------------------------------------------

  always_comb begin
    for (int unsigned i = 0; i < NUM_MST; i++) begin
      m_ar_valid_o[i] = ar_valid & (ar_beat_i.sel == sel_t'(i));
    end
  end

  assign m_ar_id_o   = ar_beat_i.id;
  assign m_ar_addr_o = ar_beat_i.addr;
  assign m_ar_len_o  = ar_beat_i.len;

endmodule

`default_nettype wire

// File: r_arbiter.sv
/*
 * R arbiter
 * round-robin merge of the master R channels with lock-in on a stalled
 * grant, pulses completion on every accepted last beat
 */

`default_nettype none

module r_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // master R channels
  input  logic [demux_pkg::NUM_MST-1:0]         m_r_valid_i,
  output logic [demux_pkg::NUM_MST-1:0]         m_r_ready_o,
  input  demux_pkg::id_t [demux_pkg::NUM_MST-1:0]   m_r_id_i,
  input  demux_pkg::data_t [demux_pkg::NUM_MST-1:0] m_r_data_i,
  input  logic [demux_pkg::NUM_MST-1:0]         m_r_last_i,
  // merged output towards the R spill register
  output logic                                  r_valid_o,
  input  logic                                  r_ready_i,
  output demux_pkg::r_beat_t                    r_beat_o,
  // completion towards dispatch
  output logic                                  r_done_o,
  output demux_pkg::id_t                        r_done_id_o
);

  import demux_pkg::*;

  sel_t rr_q;
  sel_t lock_idx_q;
  logic lock_q;
  sel_t idx;
  logic found;
  logic xfer;

  // ------------------------------------------------------------------------
  // grant selection
  // ------------------------------------------------------------------------

  always_comb begin
    sel_t cand;
    idx   = lock_idx_q;
    found = lock_q;
    cand  = rr_q;
    if (!lock_q) begin
      // search starts one past the last granted master
      for (int unsigned off = 1; off <= NUM_MST; off++) begin
        cand = sel_t'(rr_q + sel_t'(off));
        if (!found && m_r_valid_i[cand]) begin
          idx   = cand;
          found = 1'b1;
        end
      end
    end
  end

  assign r_valid_o = found & m_r_valid_i[idx];
  assign xfer      = r_valid_o & r_ready_i;

  // only the granted master sees ready
  always_comb begin
    m_r_ready_o = '0;
    m_r_ready_o[idx] = found & r_ready_i;
  end

  assign r_beat_o.id   = m_r_id_i[idx];
  assign r_beat_o.data = m_r_data_i[idx];
  assign r_beat_o.last = m_r_last_i[idx];

  // counters fall with the last beat entering the spill register
  assign r_done_o    = xfer & m_r_last_i[idx];
  assign r_done_id_o = m_r_id_i[idx];

  // ------------------------------------------------------------------------
  // lock and round-robin pointer
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= sel_t'(NUM_MST - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (xfer) begin
        lock_q <= 1'b0;
        rr_q   <= idx;
      end else if (r_valid_o) begin
        // hold the grant until the beat is taken
        lock_q     <= 1'b1;
        lock_idx_q <= idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: demux_top.sv
/*
 * AXI read demux top
 * one slave read port fanned out to four master read ports, AR spill,
 * dispatch, R arbitration and R spill in a row
 */

`default_nettype none

module demux_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // slave AR
  input  logic                                    s_ar_valid_i,
  output logic                                    s_ar_ready_o,
  input  demux_pkg::id_t                          s_ar_id_i,
  input  demux_pkg::addr_t                        s_ar_addr_i,
  input  demux_pkg::len_t                         s_ar_len_i,
  input  demux_pkg::sel_t                         s_ar_sel_i,
  // slave R
  output logic                                    s_r_valid_o,
  input  logic                                    s_r_ready_i,
  output demux_pkg::id_t                          s_r_id_o,
  output demux_pkg::data_t                        s_r_data_o,
  output logic                                    s_r_last_o,
  // master AR
  output logic [demux_pkg::NUM_MST-1:0]           m_ar_valid_o,
  input  logic [demux_pkg::NUM_MST-1:0]           m_ar_ready_i,
  output demux_pkg::id_t                          m_ar_id_o,
  output demux_pkg::addr_t                        m_ar_addr_o,
  output demux_pkg::len_t                         m_ar_len_o,
  // master R
  input  logic [demux_pkg::NUM_MST-1:0]           m_r_valid_i,
  output logic [demux_pkg::NUM_MST-1:0]           m_r_ready_o,
  input  demux_pkg::id_t [demux_pkg::NUM_MST-1:0]   m_r_id_i,
  input  demux_pkg::data_t [demux_pkg::NUM_MST-1:0] m_r_data_i,
  input  logic [demux_pkg::NUM_MST-1:0]           m_r_last_i
);

  import demux_pkg::*;

  // spilled request into dispatch
  logic     ar_valid;
  logic     ar_ready;
  ar_beat_t ar_beat;

  // merged read data into the R spill register
  logic     r_valid;
  logic     r_ready;
  r_beat_t  r_beat;
  r_beat_t  s_r_beat;

  // completion pulse back to the tracker
  logic     r_done;
  id_t      r_done_id;

  // ------------------------------------------------------------------------
  // AR path
  // ------------------------------------------------------------------------

  spill_reg #(
    .T ( ar_beat_t )
  ) u_ar_spill (
    .clk_i   ( clk_i                                                  ),
    .rst_n_i ( rst_n_i                                                ),
    .valid_i ( s_ar_valid_i                                           ),
    .ready_o ( s_ar_ready_o                                           ),
    .data_i  ( {s_ar_id_i, s_ar_addr_i, s_ar_len_i, s_ar_sel_i}       ),
    .valid_o ( ar_valid                                               ),
    .ready_i ( ar_ready                                               ),
    .data_o  ( ar_beat                                                )
  );

  ar_dispatch u_ar_dispatch (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .ar_valid_i   ( ar_valid     ),
    .ar_ready_o   ( ar_ready     ),
    .ar_beat_i    ( ar_beat      ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .m_ar_id_o    ( m_ar_id_o    ),
    .m_ar_addr_o  ( m_ar_addr_o  ),
    .m_ar_len_o   ( m_ar_len_o   ),
    .r_done_i     ( r_done       ),
    .r_done_id_i  ( r_done_id    )
  );

  // ------------------------------------------------------------------------
  // R path
  // ------------------------------------------------------------------------

  r_arbiter u_r_arbiter (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .m_r_valid_i ( m_r_valid_i ),
    .m_r_ready_o ( m_r_ready_o ),
    .m_r_id_i    ( m_r_id_i    ),
    .m_r_data_i  ( m_r_data_i  ),
    .m_r_last_i  ( m_r_last_i  ),
    .r_valid_o   ( r_valid     ),
    .r_ready_i   ( r_ready     ),
    .r_beat_o    ( r_beat      ),
    .r_done_o    ( r_done      ),
    .r_done_id_o ( r_done_id   )
  );

  spill_reg #(
    .T ( r_beat_t )
  ) u_r_spill (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .valid_i ( r_valid     ),
    .ready_o ( r_ready     ),
    .data_i  ( r_beat      ),
    .valid_o ( s_r_valid_o ),
    .ready_i ( s_r_ready_i ),
    .data_o  ( s_r_beat    )
  );

  // unpack onto the slave R port
  assign s_r_id_o   = s_r_beat.id;
  assign s_r_data_o = s_r_beat.data;
  assign s_r_last_o = s_r_beat.last;

endmodule

`default_nettype wire

// File: tb_demux_assert.sv
/*
 * handshake stability checks
 * valid and payload hold while the receiver is not ready
 */

`default_nettype none

module tb_demux_assert #(
  parameter int W = 1
) (
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         valid_i,
  input logic         ready_i,
  input logic [W-1:0] data_i
);

  // raised for good once either property has failed
  logic failed = 1'b0;

  // a stalled offer keeps valid up
  property valid_held;
    @(posedge clk_i) disable iff (!rst_n_i)
      valid_i && !ready_i |=> valid_i;
  endproperty

  property data_held;
    @(posedge clk_i) disable iff (!rst_n_i)
      valid_i && !ready_i |=> $stable(data_i);
  endproperty

  valid_held_a: assert property (valid_held)
    else begin
      $error("valid dropped before the transfer");
      failed = 1'b1;
    end

  data_held_a: assert property (data_held)
    else begin
      $error("payload changed before the transfer");
      failed = 1'b1;
    end

endmodule

// on the master AR side the one-hot valid counts as payload
bind ar_dispatch tb_demux_assert #(
  .W ( demux_pkg::NUM_MST + demux_pkg::ID_W + demux_pkg::ADDR_W + demux_pkg::LEN_W )
) u_ar_out_assert (
  .clk_i   ( clk_i                                              ),
  .rst_n_i ( rst_n_i                                            ),
  .valid_i ( |m_ar_valid_o                                      ),
  .ready_i ( |(m_ar_valid_o & m_ar_ready_i)                     ),
  .data_i  ( {m_ar_valid_o, m_ar_id_o, m_ar_addr_o, m_ar_len_o} )
);

// output side of both spill registers
bind spill_reg tb_demux_assert #(
  .W ( $bits(data_o) )
) u_spill_out_assert (
  .clk_i   ( clk_i   ),
  .rst_n_i ( rst_n_i ),
  .valid_i ( valid_o ),
  .ready_i ( ready_i ),
  .data_i  ( data_o  )
);

`default_nettype wire

// File: tb_demux.sv
/*
 * read demux testbench
 * feeds a table of read requests into the slave AR port, answers them from
 * four master models and scores routing, ordering and the merged read data
 */

`default_nettype none

module tb_demux;

  import demux_pkg::*;

  localparam int NUM_ENT  = 20;
  localparam int RST_CYC  = 16;
  localparam int HOLD_CYC = 80;
  localparam int CNT_MAX  = (1 << CNT_W) - 1;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    sel_t  sel;
    logic  stall;
  } entry_t;

  // ------------------------------------------------------------------------
  // request table with id, addr, len, sel and stall per row
  // stall keeps the target master's R channel quiet for HOLD_CYC cycles
  // ------------------------------------------------------------------------

  entry_t tbl [NUM_ENT] = '{
    {4'd1,  16'h1000, 4'd3,  2'd0, 1'b1},
    // same low id bits as above on another master
    {4'd5,  16'h1100, 4'd1,  2'd1, 1'b0},
    {4'd2,  16'h2000, 4'd0,  2'd2, 1'b0},
    {4'd3,  16'h2100, 4'd2,  2'd3, 1'b0},
    // eight reads of one id against a held master fill the counter
    {4'd6,  16'h3000, 4'd2,  2'd2, 1'b1},
    {4'd6,  16'h3010, 4'd0,  2'd2, 1'b0},
    {4'd6,  16'h3020, 4'd1,  2'd2, 1'b0},
    {4'd6,  16'h3030, 4'd3,  2'd2, 1'b0},
    {4'd6,  16'h3040, 4'd0,  2'd2, 1'b0},
    {4'd6,  16'h3050, 4'd2,  2'd2, 1'b0},
    {4'd6,  16'h3060, 4'd1,  2'd2, 1'b0},
    {4'd6,  16'h3070, 4'd0,  2'd2, 1'b0},
    {4'd0,  16'h4000, 4'd7,  2'd3, 1'b0},
    {4'd4,  16'h4100, 4'd2,  2'd0, 1'b0},
    {4'd9,  16'h5000, 4'd4,  2'd1, 1'b0},
    {4'd13, 16'h5100, 4'd0,  2'd1, 1'b0},
    {4'd7,  16'h6000, 4'd15, 2'd0, 1'b0},
    {4'd11, 16'h6100, 4'd1,  2'd2, 1'b0},
    {4'd14, 16'h7000, 4'd3,  2'd3, 1'b0},
    {4'd15, 16'h7100, 4'd0,  2'd1, 1'b1}
  };

  // DUT ports
  logic                 clk_i;
  logic                 rst_n_i;
  logic                 s_ar_valid_i;
  logic                 s_ar_ready_o;
  id_t                  s_ar_id_i;
  addr_t                s_ar_addr_i;
  len_t                 s_ar_len_i;
  sel_t                 s_ar_sel_i;
  logic                 s_r_valid_o;
  logic                 s_r_ready_i;
  id_t                  s_r_id_o;
  data_t                s_r_data_o;
  logic                 s_r_last_o;
  logic [NUM_MST-1:0]   m_ar_valid_o;
  logic [NUM_MST-1:0]   m_ar_ready_i;
  id_t                  m_ar_id_o;
  addr_t                m_ar_addr_o;
  len_t                 m_ar_len_o;
  logic [NUM_MST-1:0]   m_r_valid_i;
  logic [NUM_MST-1:0]   m_r_ready_o;
  id_t [NUM_MST-1:0]    m_r_id_i;
  data_t [NUM_MST-1:0]  m_r_data_i;
  logic [NUM_MST-1:0]   m_r_last_i;

  // model state
  int          ar_exp_q[$];
  int          pend_q[$];
  int          r_exp_q[$];
  int          r_seen [NUM_ENT];
  int          cur_idx [NUM_MST];
  int          cur_beat [NUM_MST];
  logic        cur_act [NUM_MST];
  int          hold_cnt [NUM_MST];
  logic        r_taken [NUM_MST];
  logic        ar_taken;
  int          out_cnt [NUM_LOOK];
  sel_t        out_sel [NUM_LOOK];
  int          full_hits;
  int          ar_ptr;
  logic        run;
  logic [31:0] lfsr_q;

  demux_top u_dut (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .s_ar_valid_i ( s_ar_valid_i ),
    .s_ar_ready_o ( s_ar_ready_o ),
    .s_ar_id_i    ( s_ar_id_i    ),
    .s_ar_addr_i  ( s_ar_addr_i  ),
    .s_ar_len_i   ( s_ar_len_i   ),
    .s_ar_sel_i   ( s_ar_sel_i   ),
    .s_r_valid_o  ( s_r_valid_o  ),
    .s_r_ready_i  ( s_r_ready_i  ),
    .s_r_id_o     ( s_r_id_o     ),
    .s_r_data_o   ( s_r_data_o   ),
    .s_r_last_o   ( s_r_last_o   ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .m_ar_id_o    ( m_ar_id_o    ),
    .m_ar_addr_o  ( m_ar_addr_o  ),
    .m_ar_len_o   ( m_ar_len_o   ),
    .m_r_valid_i  ( m_r_valid_i  ),
    .m_r_ready_o  ( m_r_ready_o  ),
    .m_r_id_i     ( m_r_id_i     ),
    .m_r_data_i   ( m_r_data_i   ),
    .m_r_last_i   ( m_r_last_i   )
  );

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return b;
  endfunction

  // true once any bound handshake checker has seen a violation
  function automatic logic handshake_failed();
    return u_dut.u_ar_dispatch.u_ar_out_assert.failed |
           u_dut.u_ar_spill.u_spill_out_assert.failed |
           u_dut.u_r_spill.u_spill_out_assert.failed;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus 1 time unit after each rising edge
  // ------------------------------------------------------------------------

  always @(posedge clk_i) begin : drive
    int pos;
    #1;
    if (run) begin
      s_r_ready_i = take_bit();
      for (int i = 0; i < NUM_MST; i++) begin
        m_ar_ready_i[i] = take_bit();
      end
      // an offer on the slave AR port stays until accepted
      if (!s_ar_valid_i || ar_taken) begin
        if (ar_ptr < NUM_ENT && take_bit()) begin
          s_ar_valid_i = 1'b1;
          s_ar_id_i    = tbl[ar_ptr].id;
          s_ar_addr_i  = tbl[ar_ptr].addr;
          s_ar_len_i   = tbl[ar_ptr].len;
          s_ar_sel_i   = tbl[ar_ptr].sel;
          ar_ptr++;
        end else begin
          s_ar_valid_i = 1'b0;
        end
      end
      // master models answer their requests in arrival order
      for (int i = 0; i < NUM_MST; i++) begin
        if (!cur_act[i]) begin
          pos = -1;
          for (int k = 0; k < pend_q.size(); k++) begin
            if (pos < 0 && tbl[pend_q[k]].sel == sel_t'(i)) begin
              pos = k;
            end
          end
          if (pos >= 0) begin
            cur_idx[i]  = pend_q[pos];
            pend_q.delete(pos);
            cur_act[i]  = 1'b1;
            cur_beat[i] = 0;
            hold_cnt[i] = tbl[cur_idx[i]].stall ? HOLD_CYC : 0;
          end
        end
        if (m_r_valid_i[i] && !r_taken[i]) begin
          // pending beat stays as it is
        end else if (cur_act[i] && hold_cnt[i] > 0) begin
          hold_cnt[i]--;
          m_r_valid_i[i] = 1'b0;
        end else if (cur_act[i] && take_bit()) begin
          m_r_valid_i[i] = 1'b1;
          m_r_id_i[i]    = tbl[cur_idx[i]].id;
          m_r_data_i[i]  = data_t'(tbl[cur_idx[i]].addr) + data_t'(cur_beat[i]);
          m_r_last_i[i]  = (cur_beat[i] == int'(tbl[cur_idx[i]].len));
        end else begin
          m_r_valid_i[i] = 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // monitor and scoreboard sampled mid-cycle
  // ------------------------------------------------------------------------

  always @(negedge clk_i) begin : monitor
    int   pos;
    int   idx;
    int   lk;
    logic any_full;
    if (rst_n_i) begin
      check_value(handshake_failed(), 1'b0, "handshake stability property violated");
      any_full = 1'b0;
      for (int l = 0; l < NUM_LOOK; l++) begin
        if (out_cnt[l] == CNT_MAX) begin
          any_full = 1'b1;
        end
      end
      if (any_full) begin
        full_hits++;
      end
      check_value((m_ar_valid_o & (m_ar_valid_o - 1'b1)) == '0, 1'b1,
                  "AR valid on more than one master");
      lk = int'(m_ar_id_o[LOOK_BITS-1:0]);
      // ordering and counter limit hold before this edge's updates
      for (int i = 0; i < NUM_MST; i++) begin
        if (m_ar_valid_o[i]) begin
          check_value(out_cnt[lk] != 0 && out_sel[lk] != sel_t'(i), 1'b0,
                      "AR offered while its id is busy at another master");
          check_value(any_full, 1'b0, "AR offered while an id counter is full");
        end
      end
      for (int i = 0; i < NUM_MST; i++) begin
        if (m_ar_valid_o[i] && m_ar_ready_i[i]) begin
          pos = -1;
          for (int k = 0; k < ar_exp_q.size(); k++) begin
            if (pos < 0 && tbl[ar_exp_q[k]].sel == sel_t'(i)) begin
              pos = k;
            end
          end
          check_value(pos >= 0, 1'b1, "AR on a master with no request due");
          idx = ar_exp_q[pos];
          check_value({m_ar_id_o, m_ar_addr_o, m_ar_len_o},
                      {tbl[idx].id, tbl[idx].addr, tbl[idx].len}, "AR payload at master");
          ar_exp_q.delete(pos);
          pend_q.push_back(idx);
          out_cnt[lk]++;
          out_sel[lk] = sel_t'(i);
        end
        // last beat leaving a master closes the read
        if (m_r_valid_i[i] && m_r_ready_o[i]) begin
          if (m_r_last_i[i]) begin
            out_cnt[int'(tbl[cur_idx[i]].id[LOOK_BITS-1:0])]--;
            cur_act[i] = 1'b0;
          end
          cur_beat[i]++;
        end
      end
      if (s_r_valid_o && s_r_ready_i) begin
        pos = -1;
        for (int k = 0; k < r_exp_q.size(); k++) begin
          if (pos < 0 && tbl[r_exp_q[k]].id == s_r_id_o) begin
            pos = k;
          end
        end
        check_value(pos >= 0, 1'b1, "read beat with an id that has no read due");
        idx = r_exp_q[pos];
        check_value({s_r_data_o, s_r_last_o},
                    {data_t'(tbl[idx].addr) + data_t'(r_seen[idx]),
                     r_seen[idx] == int'(tbl[idx].len)}, "read data and last");
        r_seen[idx]++;
        if (s_r_last_o) begin
          r_exp_q.delete(pos);
        end
      end
    end
    ar_taken = s_ar_valid_i & s_ar_ready_o;
    for (int i = 0; i < NUM_MST; i++) begin
      r_taken[i] = m_r_valid_i[i] & m_r_ready_o[i];
    end
  end

  // ------------------------------------------------------------------------
  // sequence and watchdog
  // ------------------------------------------------------------------------

  initial begin
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_sel_i   = '0;
    s_r_ready_i  = 1'b0;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = '0;
    lfsr_q       = 32'ha355;
    run          = 1'b0;
    ar_ptr       = 0;
    ar_taken     = 1'b0;
    full_hits    = 0;
    for (int i = 0; i < NUM_MST; i++) begin
      cur_idx[i]  = 0;
      cur_beat[i] = 0;
      cur_act[i]  = 1'b0;
      hold_cnt[i] = 0;
      r_taken[i]  = 1'b0;
    end
    for (int l = 0; l < NUM_LOOK; l++) begin
      out_cnt[l] = 0;
      out_sel[l] = '0;
    end
    for (int e = 0; e < NUM_ENT; e++) begin
      ar_exp_q.push_back(e);
      r_exp_q.push_back(e);
      r_seen[e] = 0;
    end
    rst_n_i = 1'b0;
    repeat (RST_CYC) begin
      @(negedge clk_i);
      check_value(s_r_valid_o, 1'b0, "s_r_valid_o during reset");
      check_value(m_ar_valid_o, '0, "m_ar_valid_o during reset");
    end
    @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value(s_r_valid_o, 1'b0, "s_r_valid_o right after reset");
    check_value(m_ar_valid_o, '0, "m_ar_valid_o right after reset");
    run = 1'b1;
    while (ar_exp_q.size() != 0 || r_exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // quiet window to catch stray beats
    repeat (20) begin
      @(negedge clk_i);
    end
    check_value(handshake_failed(), 1'b0, "handshake stability property violated");
    check_value(full_hits > 0, 1'b1, "no cycle with an id counter at its limit");
    $display("Verification passed");
    $finish;
  end

  initial begin
    repeat (RST_CYC + 20 + NUM_ENT * 200) begin
      @(posedge clk_i);
    end
    $display("Error at time %0t: watchdog expired with reads still outstanding", $time);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: project.f
demux_pkg.sv
spill_reg.sv
ar_id_tracker.sv
ar_dispatch.sv
r_arbiter.sv
demux_top.sv
tb_demux_assert.sv
tb_demux.sv
